//--- filelist.f
+incdir+test
logic/amiga_kbd_pkg.sv
logic/scancode_rom.sv
logic/prefix_tracker.sv
logic/key_event_decoder.sv
logic/pad_emulator.sv
logic/ps2_amiga_keymap.sv
test/ps2_amiga_keymap_tb.sv

//--- logic/amiga_kbd_pkg.sv
/* shared types and key codes for the ps/2 to amiga keymap.
   import into any block that decodes the lookup table word */
`default_nettype none

package amiga_kbd_pkg;

  typedef logic [7:0] ps2_code_t;    // one byte from the ps/2 link
  typedef logic [6:0] amiga_code_t;  // raw amiga key code
  typedef logic [7:0] amiga_key_t;   // upstroke flag on top of the code

  // table word when it describes a real key
  typedef struct packed {
    logic        amiga;    // key has an amiga code
    logic        ctrl;
    logic        aleft;
    logic        aright;
    logic        caps;
    logic        numlock;  // toggles pad mode
    logic        keypad;   // blocked in pad mode
    logic        osd;      // extra key for the on-screen display
    logic        prefix;   // clear for real keys
    amiga_code_t code;
  } key_view_t;

  // table word when it describes a prefix byte (prefix bit set)
  typedef struct packed {
    logic [7:0] flags;     // same upper bits as the key view, zero here
    logic       prefix;
    logic [3:0] spare;
    logic       is_ack;    // fa
    logic       is_release; // f0
    logic       is_ext;    // e0
  } prefix_view_t;

  typedef union packed {
    key_view_t    key;
    prefix_view_t pfx;
    logic [15:0]  raw;  // as stored in the table
  } keyrom_word_t;

  // joystick directions in pad mode
  localparam amiga_code_t KEY_ARROW_UP    = 7'h4C;
  localparam amiga_code_t KEY_ARROW_DOWN  = 7'h4D;
  localparam amiga_code_t KEY_ARROW_LEFT  = 7'h4F;
  localparam amiga_code_t KEY_ARROW_RIGHT = 7'h4E;

  // mouse buttons in pad mode
  localparam amiga_code_t KEY_KP_DIVIDE   = 7'h5C;
  localparam amiga_code_t KEY_KP_MULTIPLY = 7'h5D;

  localparam amiga_code_t KEY_FREEZE = 7'h6F;  // ctrl+break osd code for action replay

  // set 2 prefix bytes
  localparam ps2_code_t PS2_EXT_BYTE     = 8'hE0;
  localparam ps2_code_t PS2_RELEASE_BYTE = 8'hF0;
  localparam ps2_code_t PS2_ACK_BYTE     = 8'hFA;

endpackage

`default_nettype wire

//--- logic/key_event_decoder.sv
/* turns a table entry into the amiga key strobe, modifier levels,
   numlock mode, osd control byte and the freeze level */
`timescale 1ns/1ps
`default_nettype none

module key_event_decoder import amiga_kbd_pkg::*; (
  input  wire          clk,
  input  wire          reset,
  input  keyrom_word_t entry,
  input  wire          entry_valid,
  input  wire          upstroke,
  output logic         valid,
  output amiga_key_t   akey,
  output logic         ctrl,
  output logic         aleft,
  output logic         aright,
  output logic         caps,
  output logic         numlock,
  output amiga_key_t   osd_ctrl,
  output logic         freeze
);

  logic is_arrow;
  logic pad_owned;  // key taken over by the pad emulator

  assign is_arrow = entry.key.code inside {KEY_ARROW_UP, KEY_ARROW_DOWN,
                                           KEY_ARROW_LEFT, KEY_ARROW_RIGHT};

  assign pad_owned = numlock && (entry.key.keypad || is_arrow ||
                                 entry.key.ctrl || entry.key.aleft);

  assign valid = entry_valid && entry.key.amiga && !pad_owned;
  assign akey  = {upstroke, entry.key.code};

  // ctrl and left alt become fire buttons in pad mode
  assign ctrl   = entry.key.ctrl && !numlock;
  assign aleft  = entry.key.aleft && !numlock;
  assign aright = entry.key.aright;
  assign caps   = entry.key.caps;

  always_ff @(posedge clk) begin
    if (reset)
      numlock <= 1'b0;
    else if (entry_valid && entry.key.numlock && !upstroke)
      numlock <= !numlock;  // toggles on press only
  end

  always_ff @(posedge clk) begin
    if (reset)
      osd_ctrl <= '0;
    else if (entry_valid && (entry.key.osd || entry.key.amiga))
      osd_ctrl <= akey;
  end

  // action replay freeze held while ctrl+break is down
  always_ff @(posedge clk) begin
    if (reset)
      freeze <= 1'b0;
    else if (entry_valid && entry.key.osd && entry.key.code == KEY_FREEZE)
      freeze <= !upstroke;
  end

endmodule

`default_nettype wire

//--- logic/pad_emulator.sv
/* numlock mode joystick and mouse button emulation from arrows, ctrl,
   left alt and keypad divide/multiply; all lines active low */
`timescale 1ns/1ps
`default_nettype none

module pad_emulator import amiga_kbd_pkg::*; (
  input  wire          clk,
  input  wire          reset,
  input  wire          numlock,
  input  keyrom_word_t entry,
  input  wire          entry_valid,
  input  wire          upstroke,
  output logic [5:0]   joy2_n,  // fire2, fire, up, down, left, right
  output logic         lmb_n,
  output logic         rmb_n
);

  logic       amiga_hit;
  logic       press;
  logic       hit_up;
  logic       hit_down;
  logic       hit_left;
  logic       hit_right;
  logic [7:0] follow_hit;   // line takes the upstroke value
  logic [7:0] release_hit;  // line forced high
  logic [7:0] line_n;       // rmb, lmb, then the joystick bits

  assign amiga_hit = entry_valid && entry.key.amiga;
  assign press     = !upstroke;

  assign hit_up    = amiga_hit && entry.key.code == KEY_ARROW_UP;
  assign hit_down  = amiga_hit && entry.key.code == KEY_ARROW_DOWN;
  assign hit_left  = amiga_hit && entry.key.code == KEY_ARROW_LEFT;
  assign hit_right = amiga_hit && entry.key.code == KEY_ARROW_RIGHT;

  assign follow_hit = {amiga_hit && entry.key.code == KEY_KP_MULTIPLY,
                       amiga_hit && entry.key.code == KEY_KP_DIVIDE,
                       amiga_hit && entry.key.aleft,
                       amiga_hit && entry.key.ctrl,
                       hit_up, hit_down, hit_left, hit_right};

  // pressing the opposite arrow lets go of a direction
  assign release_hit = {4'b0000,
                        press && hit_down,
                        press && hit_up,
                        press && hit_right,
                        press && hit_left};

  always_ff @(posedge clk) begin
    for (int i = 0; i < 8; i++) begin
      if (reset || !numlock || release_hit[i])
        line_n[i] <= 1'b1;
      else if (follow_hit[i])
        line_n[i] <= upstroke;  // low while held
    end
  end

  assign joy2_n = line_n[5:0];
  assign lmb_n  = line_n[6];
  assign rmb_n  = line_n[7];

endmodule

`default_nettype wire

//--- logic/prefix_tracker.sv
/* follows e0, f0 and fa bytes so the next real key knows whether it is
   extended and whether it is a release */
`timescale 1ns/1ps
`default_nettype none

module prefix_tracker import amiga_kbd_pkg::*; (
  input  wire          clk,
  input  wire          reset,
  input  keyrom_word_t entry,
  input  wire          entry_valid,
  output logic         extended,
  output logic         upstroke
);

  logic ext_hit;
  logic rel_hit;
  logic ack_hit;

  assign ext_hit = entry.pfx.prefix && entry.pfx.is_ext;
  assign rel_hit = entry.pfx.prefix && entry.pfx.is_release;
  assign ack_hit = entry.pfx.prefix && entry.pfx.is_ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      extended <= 1'b0;
      upstroke <= 1'b0;
    end else if (entry_valid) begin
      if (ext_hit)
        extended <= 1'b1;
      else if (rel_hit)
        upstroke <= 1'b1;  // e0 state kept for e0 f0 xx
      else if (!ack_hit) begin
        // any real key ends the prefix sequence
        extended <= 1'b0;
        upstroke <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/ps2_amiga_keymap.sv
/* ps/2 set 2 to amiga keymap top level. feed one byte per enable strobe,
   at least two idle cycles apart */
`timescale 1ns/1ps
`default_nettype none

module ps2_amiga_keymap import amiga_kbd_pkg::*; (
  input  wire        clk,
  input  wire        reset,
  input  wire        enable,
  input  ps2_code_t  ps2key,
  output logic       valid,
  output amiga_key_t akey,
  output logic       ctrl,
  output logic       aleft,
  output logic       aright,
  output logic       caps,
  output logic       numlock,
  output amiga_key_t osd_ctrl,
  output logic       freeze,
  output logic [5:0] joy2_n,
  output logic       lmb_n,
  output logic       rmb_n
);

  keyrom_word_t entry;
  logic         entry_valid;
  logic         extended;
  logic         upstroke;

  scancode_rom rom_i (
    .clk         (clk),
    .reset       (reset),
    .enable      (enable),
    .ps2key      (ps2key),
    .extended    (extended),
    .entry       (entry),
    .entry_valid (entry_valid)
  );

  prefix_tracker prefix_i (
    .clk         (clk),
    .reset       (reset),
    .entry       (entry),
    .entry_valid (entry_valid),
    .extended    (extended),
    .upstroke    (upstroke)
  );

  key_event_decoder decoder_i (
    .clk         (clk),
    .reset       (reset),
    .entry       (entry),
    .entry_valid (entry_valid),
    .upstroke    (upstroke),
    .valid       (valid),
    .akey        (akey),
    .ctrl        (ctrl),
    .aleft       (aleft),
    .aright      (aright),
    .caps        (caps),
    .numlock     (numlock),
    .osd_ctrl    (osd_ctrl),
    .freeze      (freeze)
  );

  // joystick and buttons only move in numlock mode
  pad_emulator pad_i (
    .clk         (clk),
    .reset       (reset),
    .numlock     (numlock),
    .entry       (entry),
    .entry_valid (entry_valid),
    .upstroke    (upstroke),
    .joy2_n      (joy2_n),
    .lmb_n       (lmb_n),
    .rmb_n       (rmb_n)
  );

endmodule

`default_nettype wire

//--- logic/scancode_rom.sv
/* registered scan code set 2 lookup table; one entry per ps/2 byte,
   addressed together with the extended prefix state */
`timescale 1ns/1ps
`default_nettype none

module scancode_rom import amiga_kbd_pkg::*; (
  input  wire          clk,
  input  wire          reset,
  input  wire          enable,       // new byte strobe
  input  ps2_code_t    ps2key,
  input  wire          extended,     // e0 seen before this byte
  output keyrom_word_t entry,
  output logic         entry_valid   // enable delayed to match the table
);

  logic [8:0]   rom_addr;
  keyrom_word_t lookup;

  assign rom_addr = {extended, ps2key};

  // only the mapped rows; all other addresses read as zero
  always_comb begin
    lookup.raw = 16'h0000;
    case (rom_addr)
      9'h001: lookup.raw = 16'h8058;  // f9
      9'h003: lookup.raw = 16'h8054;  // f5
      9'h004: lookup.raw = 16'h8052;  // f3
      9'h005: lookup.raw = 16'h8050;  // f1
      9'h006: lookup.raw = 16'h8051;  // f2
      9'h007: lookup.raw = 16'h0169;  // f12 as osd key
      9'h009: lookup.raw = 16'h8059;  // f10
      9'h00a: lookup.raw = 16'h8057;  // f8
      9'h00b: lookup.raw = 16'h8055;  // f6
      9'h00c: lookup.raw = 16'h8053;  // f4
      9'h00d: lookup.raw = 16'h8042;  // tab
      9'h00e: lookup.raw = 16'h8000;  // backtick
      9'h011: lookup.raw = 16'hA064;  // left alt
      9'h012: lookup.raw = 16'h8060;  // left shift
      9'h014: lookup.raw = 16'hC063;  // ctrl
      9'h015: lookup.raw = 16'h8010;  // q
      9'h016: lookup.raw = 16'h8001;  // 1
      9'h01a: lookup.raw = 16'h8031;  // z
      9'h01b: lookup.raw = 16'h8021;  // s
      9'h01c: lookup.raw = 16'h8020;  // a
      9'h01d: lookup.raw = 16'h8011;  // w
      9'h01e: lookup.raw = 16'h8002;  // 2
      9'h021: lookup.raw = 16'h8033;  // c
      9'h022: lookup.raw = 16'h8032;  // x
      9'h023: lookup.raw = 16'h8022;  // d
      9'h024: lookup.raw = 16'h8012;  // e
      9'h025: lookup.raw = 16'h8004;  // 4
      9'h026: lookup.raw = 16'h8003;  // 3
      9'h029: lookup.raw = 16'h8040;  // space
      9'h02a: lookup.raw = 16'h8034;  // v
      9'h02b: lookup.raw = 16'h8023;  // f
      9'h02c: lookup.raw = 16'h8014;  // t
      9'h02d: lookup.raw = 16'h8013;  // r
      9'h02e: lookup.raw = 16'h8005;  // 5
      9'h031: lookup.raw = 16'h8036;  // n
      9'h032: lookup.raw = 16'h8035;  // b
      9'h033: lookup.raw = 16'h8025;  // h
      9'h034: lookup.raw = 16'h8024;  // g
      9'h035: lookup.raw = 16'h8015;  // y
      9'h036: lookup.raw = 16'h8006;  // 6
      9'h03a: lookup.raw = 16'h8037;  // m
      9'h03b: lookup.raw = 16'h8026;  // j
      9'h03c: lookup.raw = 16'h8016;  // u
      9'h03d: lookup.raw = 16'h8007;  // 7
      9'h03e: lookup.raw = 16'h8008;  // 8
      9'h041: lookup.raw = 16'h8038;  // comma
      9'h042: lookup.raw = 16'h8027;  // k
      9'h043: lookup.raw = 16'h8017;  // i
      9'h044: lookup.raw = 16'h8018;  // o
      9'h045: lookup.raw = 16'h800A;  // 0
      9'h046: lookup.raw = 16'h8009;  // 9
      9'h049: lookup.raw = 16'h8039;  // period
      9'h04a: lookup.raw = 16'h803A;  // slash
      9'h04b: lookup.raw = 16'h8028;  // l
      9'h04c: lookup.raw = 16'h8029;  // semicolon
      9'h04d: lookup.raw = 16'h8019;  // p
      9'h04e: lookup.raw = 16'h800B;  // minus
      9'h052: lookup.raw = 16'h802A;  // quote
      9'h054: lookup.raw = 16'h801A;  // open bracket
      9'h055: lookup.raw = 16'h800C;  // equals
      9'h058: lookup.raw = 16'h8862;  // caps lock
      9'h059: lookup.raw = 16'h8061;  // right shift
      9'h05a: lookup.raw = 16'h8044;  // return
      9'h05b: lookup.raw = 16'h801B;  // close bracket
      9'h05d: lookup.raw = 16'h802B;  // iso hash key
      9'h061: lookup.raw = 16'h8030;  // iso angle key
      9'h066: lookup.raw = 16'h8041;  // backspace
      9'h069: lookup.raw = 16'h821D;  // keypad 1
      9'h06b: lookup.raw = 16'h822D;  // keypad 4
      9'h06c: lookup.raw = 16'h823D;  // keypad 7
      9'h070: lookup.raw = 16'h820F;  // keypad 0
      9'h071: lookup.raw = 16'h823C;  // keypad point
      9'h072: lookup.raw = 16'h821E;  // keypad 2
      9'h073: lookup.raw = 16'h822E;  // keypad 5
      9'h074: lookup.raw = 16'h822F;  // keypad 6
      9'h075: lookup.raw = 16'h823E;  // keypad 8
      9'h076: lookup.raw = 16'h8045;  // esc
      9'h077: lookup.raw = 16'h0400;  // num lock
      9'h079: lookup.raw = 16'h825E;  // keypad plus
      9'h07a: lookup.raw = 16'h821F;  // keypad 3
      9'h07b: lookup.raw = 16'h824A;  // keypad minus
      9'h07c: lookup.raw = 16'h825D;  // keypad multiply
      9'h07d: lookup.raw = 16'h823F;  // keypad 9
      9'h07e: lookup.raw = 16'h0169;  // scroll lock as osd key
      9'h083: lookup.raw = 16'h8056;  // f7
      9'h0e0: lookup.raw = 16'h0081;  // extended prefix
      9'h0f0: lookup.raw = 16'h0082;  // release prefix
      9'h0fa: lookup.raw = 16'h0084;  // ack
      9'h111: lookup.raw = 16'h9065;  // right alt
      9'h11f: lookup.raw = 16'h8066;  // left gui as left amiga
      9'h127: lookup.raw = 16'h8067;  // right gui as right amiga
      9'h12f: lookup.raw = 16'h8067;  // menu key also right amiga
      9'h14a: lookup.raw = 16'h825C;  // keypad divide
      9'h15a: lookup.raw = 16'h8243;  // keypad enter
      9'h169: lookup.raw = 16'h016B;  // end as osd key
      9'h16b: lookup.raw = 16'h804F;  // arrow left
      9'h16c: lookup.raw = 16'h016A;  // home as osd key
      9'h170: lookup.raw = 16'h805F;  // insert as help
      9'h171: lookup.raw = 16'h8046;  // delete
      9'h172: lookup.raw = 16'h804D;  // arrow down
      9'h174: lookup.raw = 16'h804E;  // arrow right
      9'h175: lookup.raw = 16'h804C;  // arrow up
      9'h17a: lookup.raw = 16'h016D;  // page down as osd key
      9'h17c: lookup.raw = 16'h016E;  // print screen as osd key
      9'h17d: lookup.raw = 16'h016C;  // page up as osd key
      9'h17e: lookup.raw = 16'h016F;  // ctrl+break for freeze
      9'h1e0: lookup.raw = 16'h0081;  // e0 again while extended
      9'h1f0: lookup.raw = 16'h0082;  // e0 f0 release
      9'h1fa: lookup.raw = 16'h0084;
      default: lookup.raw = 16'h0000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      entry.raw   <= 16'h0000;
      entry_valid <= 1'b0;
    end else begin
      entry_valid <= enable;  // table output lands one cycle later
      if (enable)
        entry <= lookup;
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the keymap testbench with verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module ps2_amiga_keymap_tb -f filelist.f -o keymap_sim
./obj_dir/keymap_sim

//--- test/keymap_ref.svh
/* reference model for the keymap testbench with the table rows of the tested
   keys and the per-byte prediction of every DUT output */
`ifndef KEYMAP_REF_SVH
`define KEYMAP_REF_SVH

typedef struct packed {
  logic        amiga;
  logic        ctrl;
  logic        aleft;
  logic        aright;
  logic        caps;
  logic        numlock;
  logic        keypad;
  logic        osd;
  logic        is_ext;
  logic        is_rel;
  logic        is_ack;
  amiga_code_t code;
} ref_row_t;

// carried from byte to byte and doubling as the registered outputs
typedef struct packed {
  logic       ext;
  logic       up;
  logic       numlock;
  amiga_key_t osd;
  logic       freeze;
  logic [5:0] joy;  // fire2, fire, up, down, left, right
  logic       lmb;
  logic       rmb;
} model_t;

// levels seen during the pulse window
typedef struct packed {
  logic       valid;
  amiga_key_t akey;
  logic       ctrl;
  logic       aleft;
  logic       aright;
  logic       caps;
} comb_t;

function automatic ref_row_t ref_row(input logic ext, input ps2_code_t b);
  ref_row_t r;
  r = '0;
  r.amiga = 1'b1;
  case ({ext, b})
    9'h01c: r.code = 7'h20;  // a
    9'h015: r.code = 7'h10;  // q
    9'h01a: r.code = 7'h31;  // z
    9'h005: r.code = 7'h50;  // f1
    9'h009: r.code = 7'h59;  // f10
    9'h029: r.code = 7'h40;  // space
    9'h014: r.code = 7'h63;  // ctrl
    9'h011: r.code = 7'h64;  // left alt
    9'h058: r.code = 7'h62;  // caps lock
    9'h111: r.code = 7'h65;  // right alt
    9'h11f: r.code = 7'h66;  // left amiga
    9'h127: r.code = 7'h67;  // right amiga
    9'h175: r.code = 7'h4C;
    9'h172: r.code = 7'h4D;
    9'h16b: r.code = 7'h4F;
    9'h174: r.code = 7'h4E;
    9'h14a: r.code = 7'h5C;  // keypad divide
    9'h07c: r.code = 7'h5D;  // keypad multiply
    9'h075: r.code = 7'h3E;  // keypad 8
    default: r.amiga = 1'b0;
  endcase
  r.ctrl   = r.amiga && r.code == 7'h63;
  r.aleft  = r.amiga && r.code == 7'h64;
  r.aright = r.amiga && r.code == 7'h65;
  r.caps   = r.amiga && r.code == 7'h62;
  r.keypad = r.amiga && (r.code inside {7'h5C, 7'h5D, 7'h3E});
  if (!r.amiga) begin
    case ({ext, b})
      9'h007, 9'h07e: r.code = 7'h69;  // f12 and scroll lock
      9'h17d: r.code = 7'h6C;          // page up
      9'h17a: r.code = 7'h6D;          // page down
      9'h17e: r.code = 7'h6F;          // ctrl+break for freeze
      9'h077: r.numlock = 1'b1;
      9'h0e0, 9'h1e0: r.is_ext = 1'b1;
      9'h0f0, 9'h1f0: r.is_rel = 1'b1;
      9'h0fa, 9'h1fa: r.is_ack = 1'b1;
      default: r = '0;
    endcase
    r.osd = (r.code != '0);  // only osd rows carry a code here
  end
  return r;
endfunction

// next model state for one byte with the pulse window levels in c
function automatic model_t predict(input model_t st, input ps2_code_t b, output comb_t c);
  ref_row_t r;
  model_t   n;
  logic     pad_key;
  r = ref_row(st.ext, b);
  n = st;
  pad_key = r.keypad || r.ctrl || r.aleft ||
            (r.amiga && r.code inside {7'h4C, 7'h4D, 7'h4E, 7'h4F});
  c.valid  = r.amiga && !(st.numlock && pad_key);
  c.akey   = {st.up, r.code};
  c.ctrl   = r.ctrl && !st.numlock;
  c.aleft  = r.aleft && !st.numlock;
  c.aright = r.aright;
  c.caps   = r.caps;
  if (r.is_ext)
    n.ext = 1'b1;
  else if (r.is_rel)
    n.up = 1'b1;  // extended kept for e0 f0 xx
  else if (!r.is_ack) begin
    n.ext = 1'b0;
    n.up  = 1'b0;
  end
  if (r.numlock && !st.up)
    n.numlock = !st.numlock;
  if (r.amiga || r.osd)
    n.osd = {st.up, r.code};
  if (r.osd && r.code == 7'h6F)
    n.freeze = !st.up;
  // pad lines see the mode from before this byte
  if (!st.numlock) begin
    n.joy = 6'h3F;
    n.lmb = 1'b1;
    n.rmb = 1'b1;
  end else if (r.amiga) begin
    case (r.code)
      7'h4C: begin
        n.joy[3] = st.up;
        if (!st.up)
          n.joy[2] = 1'b1;  // pressing up lets go of down
      end
      7'h4D: begin
        n.joy[2] = st.up;
        if (!st.up)
          n.joy[3] = 1'b1;
      end
      7'h4F: begin
        n.joy[1] = st.up;
        if (!st.up)
          n.joy[0] = 1'b1;
      end
      7'h4E: begin
        n.joy[0] = st.up;
        if (!st.up)
          n.joy[1] = 1'b1;
      end
      7'h5C: n.lmb = st.up;
      7'h5D: n.rmb = st.up;
      default: ;
    endcase
    if (r.ctrl)
      n.joy[4] = st.up;
    if (r.aleft)
      n.joy[5] = st.up;
  end
  return n;
endfunction

`endif

//--- test/ps2_amiga_keymap_tb.sv
/* testbench for the ps/2 to amiga keymap that replays directed and random key
   sequences and checks every byte against the reference model */
`timescale 1ns/1ps
`default_nettype none

module ps2_amiga_keymap_tb import amiga_kbd_pkg::*; ();

  localparam int CLK_PERIOD    = 40;
  localparam int DRIVE_DELAY   = 2;
  localparam int RESET_CYCLES  = 4;
  localparam int SLOT_CYCLES   = 4;  // strobe plus three idle cycles
  localparam int RANDOM_EVENTS = 48;
  localparam int SEED          = 42;

  // {release, extended, byte}
  localparam logic [9:0] DIRECTED [59] = '{
    10'h01c, 10'h21c, 10'h015, 10'h215, 10'h01a, 10'h21a, 10'h005, 10'h205,  // plain keys
    10'h009, 10'h209, 10'h029, 10'h229, 10'h002, 10'h060,
    10'h175, 10'h375, 10'h111, 10'h311, 10'h11f, 10'h31f, 10'h127, 10'h327,  // extended
    10'h014, 10'h214, 10'h011, 10'h211, 10'h058, 10'h258,                    // modifiers
    10'h007, 10'h207, 10'h07e, 10'h27e, 10'h17d, 10'h37d, 10'h17a, 10'h37a,  // osd keys
    10'h17e, 10'h37e,
    10'h077, 10'h277, 10'h175, 10'h172, 10'h372, 10'h16b, 10'h174, 10'h374,  // pad mode
    10'h014, 10'h011, 10'h14a, 10'h07c, 10'h075, 10'h214, 10'h34a, 10'h111,
    10'h077, 10'h01c, 10'h277, 10'h077, 10'h077
  };

  localparam logic [8:0] KEY_POOL [20] = '{
    9'h01c, 9'h015, 9'h005, 9'h029, 9'h014, 9'h011, 9'h058, 9'h111, 9'h11f, 9'h175,
    9'h172, 9'h16b, 9'h174, 9'h14a, 9'h07c, 9'h075, 9'h077, 9'h007, 9'h17d, 9'h17e
  };

  logic       clk = 1'b0;
  logic       reset;
  logic       enable;
  ps2_code_t  ps2key;
  logic       valid;
  amiga_key_t akey;
  logic       ctrl;
  logic       aleft;
  logic       aright;
  logic       caps;
  logic       numlock;
  amiga_key_t osd_ctrl;
  logic       freeze;
  logic [5:0] joy2_n;
  logic       lmb_n;
  logic       rmb_n;

  `include "keymap_ref.svh"

  ps2_code_t stim_q[$];
  comb_t     comb_q[$];   // expected pulse window per byte
  model_t    model_q[$];  // expected registered levels per byte
  model_t    model;
  int        checked = 0;

  ps2_amiga_keymap dut_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic fail_with(input string line);
    $display("%s", line);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_key(input string name, input amiga_key_t got, input amiga_key_t exp);
    if (got !== exp)
      fail_with($sformatf("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_with($sformatf("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp));
  endtask

  task automatic compare_joy(input string name, input logic [5:0] got, input logic [5:0] exp);
    if (got !== exp)
      fail_with($sformatf("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp));
  endtask

  // one key event as its ps/2 bytes
  task automatic add_key(input logic [9:0] ev);
    if (ev[8])
      stim_q.push_back(8'hE0);
    if (ev[9])
      stim_q.push_back(8'hF0);
    stim_q.push_back(ev[7:0]);
  endtask

  task automatic send_byte(input ps2_code_t b);
    comb_t c;
    model = predict(model, b, c);
    comb_q.push_back(c);
    model_q.push_back(model);
    ps2key = b;
    enable = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    enable = 1'b0;
    repeat (SLOT_CYCLES - 1) @(posedge clk);
    #DRIVE_DELAY;
  endtask

  initial begin
    int   idx;
    logic rel;
    reset = 1'b1;
    enable = 1'b0;
    ps2key = 8'h00;
    model = '0;
    model.joy = 6'h3F;
    model.lmb = 1'b1;
    model.rmb = 1'b1;
    void'($urandom(SEED));
    for (int i = 0; i < $size(DIRECTED); i++)
      add_key(DIRECTED[i]);
    stim_q.push_back(8'hE0);  // ack inside an extended sequence
    stim_q.push_back(8'hFA);
    stim_q.push_back(8'h6B);
    add_key(10'h36b);
    for (int i = 0; i < RANDOM_EVENTS; i++) begin
      idx = $urandom_range(0, 19);
      rel = ($urandom_range(0, 1) == 1);
      add_key({rel, KEY_POOL[idx]});
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    @(negedge clk);
    compare_bit("valid", valid, 1'b0);
    compare_key("osd_ctrl", osd_ctrl, 8'h00);
    compare_bit("freeze", freeze, 1'b0);
    compare_bit("numlock", numlock, 1'b0);
    compare_joy("joy2_n", joy2_n, 6'h3F);
    compare_bit("lmb_n", lmb_n, 1'b1);
    compare_bit("rmb_n", rmb_n, 1'b1);
    @(posedge clk);
    #DRIVE_DELAY;
    for (int i = 0; i < stim_q.size(); i++)
      send_byte(stim_q[i]);
    repeat (SLOT_CYCLES) @(posedge clk);
    if (checked == stim_q.size() && comb_q.size() == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      fail_with($sformatf("checker saw %0d of %0d bytes", checked, stim_q.size()));
    end
  end

  // pulse window after the strobe, then the registered levels
  initial begin
    comb_t  c;
    model_t m;
    forever begin
      @(posedge clk);
      if (enable) begin
        if (comb_q.size() == 0) begin
          fail_with("enable strobe seen with no expected result queued");
        end else begin
          c = comb_q.pop_front();
          m = model_q.pop_front();
          @(negedge clk);
          compare_bit("valid", valid, c.valid);
          if (c.valid)
            compare_key("akey", akey, c.akey);
          compare_bit("ctrl", ctrl, c.ctrl);
          compare_bit("aleft", aleft, c.aleft);
          compare_bit("aright", aright, c.aright);
          compare_bit("caps", caps, c.caps);
          @(negedge clk);
          compare_bit("valid", valid, 1'b0);  // single cycle pulse
          compare_bit("numlock", numlock, m.numlock);
          compare_key("osd_ctrl", osd_ctrl, m.osd);
          compare_bit("freeze", freeze, m.freeze);
          compare_joy("joy2_n", joy2_n, m.joy);
          compare_bit("lmb_n", lmb_n, m.lmb);
          compare_bit("rmb_n", rmb_n, m.rmb);
          checked++;
        end
      end
    end
  end

  initial begin
    int limit_ns;
    #1;
    limit_ns = (stim_q.size() + RESET_CYCLES) * SLOT_CYCLES * CLK_PERIOD * 2;
    #(limit_ns);
    fail_with("watchdog expired before the byte sequence finished");
  end

endmodule

`default_nettype wire
